// File: adc_trace.txt
# Each line is R <12-bit hex sample> <flag> or C for a recalibration.
# Flag 1 pulses read a second time while that frame runs.
R FFF 0
R F00 1
R C00 0
R B00 0
R 800 0
C
R 900 1
R 7FF 0
R 123 0
R 000 0
R 100 0
R 200 1
C
R 0FF 0
R 5A5 0
R A5A 0
R ABC 1
R FFF 0

// File: compile.f
+incdir+.
adc_pkg.sv
sclk_gen.sv
adc_serial_rx.sv
sample_averager.sv
level_monitor.sv
adc_top.sv
adc_properties.sv
adc_checker.sv
tb_adc_top.sv

// File: tb_adc_top.sv
`default_nettype none

`include "adc_cfg.svh"

module tb_adc_top
    import adc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam real clk_period = 40.0;
    localparam int sclk_cycles = 2 * `ADC_SCLK_HALF;  // clk cycles per sclk period.

    logic         clk;
    logic         reset;
    logic         read;
    logic         recalibrate;
    logic         sdo;
    logic         cs;
    logic         sclk;
    logic         ready;
    sample_beat_t sample;
    sample_beat_t mean;
    logic         alarm;

    byte         cmd_list[$];
    sample_t     value_list[$];
    bit          flag_list[$];
    int          setup_errors;
    bit          trace_loaded;
    logic [31:0] rand_state;
    logic [15:0] frame_word;   // Bits the ADC model sends in the next frame.
    logic [15:0] shift_q;
    logic        cs_prev;
    logic        sclk_prev;

    adc_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .read        (read),
        .recalibrate (recalibrate),
        .sdo         (sdo),
        .cs          (cs),
        .sclk        (sclk),
        .ready       (ready),
        .sample      (sample),
        .mean        (mean),
        .alarm       (alarm)
    );

    adc_checker chk0 (
        .clk    (clk),
        .reset  (reset),
        .cs     (cs),
        .sclk   (sclk),
        .ready  (ready),
        .sample (sample),
        .mean   (mean),
        .alarm  (alarm)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int error_total();
        return chk0.value_errors + chk0.protocol_errors + dut0.prop0.fail_count + setup_errors;
    endfunction

    task automatic print_counts();
        $display("Checks: %0d, errors: %0d value, %0d protocol, %0d assertion, %0d setup",
                 chk0.checks, chk0.value_errors, chk0.protocol_errors,
                 dut0.prop0.fail_count, setup_errors);
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          flag;
        logic [11:0] value;
        string       line;
        fd = $fopen("adc_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open adc_trace.txt");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) == "R") begin
                    flag = 0;
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %d", value, flag);
                    if (n < 1) begin
                        $display("Trace line without a sample value: %s", line);
                        setup_errors++;
                    end else begin
                        cmd_list.push_back("R");
                        value_list.push_back(value);
                        flag_list.push_back(flag != 0);
                    end
                end else if (n > 0 && line.getc(0) == "C") begin
                    cmd_list.push_back("C");
                    value_list.push_back('0);
                    flag_list.push_back(1'b0);
                end
            end
            $fclose(fd);
        end
        trace_loaded = 1'b1;
    endtask

    task automatic wait_ready();
        while (ready !== 1'b1) @(negedge clk);
    endtask

    task automatic pulse_read();
        read = 1'b1;
        @(negedge clk);
        read = 1'b0;
    endtask

    task automatic start_read(input sample_t value, input bit twice);
        frame_word = {{`ADC_LEAD_BITS{1'b0}}, value};
        chk0.expect_read(value);
        pulse_read();
        if (twice) begin
            while (cs !== 1'b0) @(negedge clk);
            repeat (6) @(negedge clk);
            pulse_read();  // Lands inside the frame.
        end
    endtask

    task automatic start_recalibration();
        rand_state = next_random(rand_state);
        frame_word = rand_state[15:0];  // Noise on sdo during calibration.
        chk0.expect_cal();
        recalibrate = 1'b1;
        @(negedge clk);
        recalibrate = 1'b0;
    endtask

    // The ADC model steps to the next bit on each sclk fall inside a frame.
    always @(negedge clk) begin
        if (!cs && cs_prev) begin
            shift_q = frame_word;
        end else if (!cs && !sclk && sclk_prev) begin
            shift_q = shift_q << 1;
        end
        sdo = cs ? 1'b0 : shift_q[15];
        cs_prev = cs;
        sclk_prev = sclk;
    end

    initial begin : stimulus
        reset = 1'b1;
        read = 1'b0;
        recalibrate = 1'b0;
        sdo = 1'b0;
        cs_prev = 1'b1;
        sclk_prev = 1'b1;
        shift_q = '0;
        setup_errors = 0;
        rand_state = 32'd42886;
        load_trace();
        rand_state = next_random(rand_state);
        frame_word = rand_state[15:0];
        chk0.expect_cal();  // Power-up calibration.
        repeat (4) @(negedge clk);
        reset = 1'b0;
        foreach (cmd_list[i]) begin
            wait_ready();
            if (cmd_list[i] == "C") begin
                start_recalibration();
            end else begin
                start_read(value_list[i], flag_list[i]);
            end
        end
        wait_ready();
        repeat (4) @(negedge clk);
        chk0.check_leftovers();
        print_counts();
        if (error_total() == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        real limit;
        wait (trace_loaded);
        limit = ((cmd_list.size() * 40 + `ADC_CAL_BITS) * sclk_cycles + 4) * clk_period;
        #(limit);
        $display("Timeout: the trace did not finish within %0.0f ns", limit);
        print_counts();
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: adc_checker.sv
`default_nettype none

`include "adc_cfg.svh"

module adc_checker
    import adc_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         cs,
    input logic         sclk,
    input logic         ready,
    input sample_beat_t sample,
    input sample_beat_t mean,
    input logic         alarm
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int period_clks = 2 * `ADC_SCLK_HALF;
    localparam int block_size = 1 << `ADC_AVG_LOG2;

    int      checks = 0;
    int      value_errors = 0;
    int      protocol_errors = 0;
    bit      kind_q[$];         // 1 for a read frame and 0 for a calibration.
    sample_t value_q[$];
    sample_t mean_q[$];
    bit      in_frame;
    bit      cur_is_read;
    sample_t cur_value;
    int      low_cycles;
    int      frame_samples;
    int      block_sum;
    int      block_count;
    logic    cs_prev;
    logic    alarm_prev;
    logic    exp_alarm;
    bit      alarm_due;

    task automatic expect_read(input sample_t value);
        kind_q.push_back(1'b1);
        value_q.push_back(value);
    endtask

    task automatic expect_cal();
        kind_q.push_back(1'b0);
        value_q.push_back('0);
    endtask

    task automatic compare_value(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("[ERROR] %s: expected 0x%0h, got 0x%0h at %0t ns",
                     name, expected, actual, $time);
        end
    endtask

    task automatic protocol_error(input string what);
        protocol_errors++;
        $display("Protocol error at %0t ns: %s", $time, what);
    endtask

    task automatic start_frame();
        in_frame = 1'b1;
        low_cycles = 0;
        frame_samples = 0;
        cur_is_read = 1'b0;
        if (kind_q.size() == 0) begin
            protocol_error("cs fell although no frame was requested");
            return;
        end
        cur_is_read = kind_q.pop_front();
        cur_value = value_q.pop_front();
        if (cur_is_read) begin
            block_sum += cur_value;
            block_count++;
            if (block_count == block_size) begin
                mean_q.push_back(sample_t'(block_sum / block_size));  // Truncated mean.
                block_sum = 0;
                block_count = 0;
            end
        end
    endtask

    task automatic end_frame();
        int expected_cycles;
        expected_cycles = period_clks * (cur_is_read ? `ADC_FRAME_BITS : `ADC_CAL_BITS);
        in_frame = 1'b0;
        checks++;
        if (low_cycles != expected_cycles) begin
            protocol_error($sformatf("cs stayed low for %0d clk cycles instead of %0d",
                                     low_cycles, expected_cycles));
        end
        if (frame_samples != (cur_is_read ? 1 : 0)) begin
            protocol_error($sformatf("a %s frame gave %0d samples",
                                     cur_is_read ? "read" : "calibration", frame_samples));
        end
        compare_value("ready", 1'b1, ready);
    endtask

    task automatic check_sample();
        frame_samples++;
        if (!in_frame || !cur_is_read) begin
            protocol_error("sample.valid outside a read frame");
        end else if (frame_samples == 1) begin
            compare_value("sample.data", cur_value, sample.data);
        end
    endtask

    task automatic check_mean();
        sample_t expected;
        if (mean_q.size() == 0) begin
            protocol_error("mean.valid without a completed block");
            return;
        end
        expected = mean_q.pop_front();
        compare_value("mean.data", expected, mean.data);
        if (expected > `ADC_ALARM_HIGH) begin
            exp_alarm = 1'b1;
        end else if (expected < `ADC_ALARM_LOW) begin
            exp_alarm = 1'b0;
        end
        alarm_due = 1'b1;  // Alarm settles one cycle later.
    endtask

    task automatic check_leftovers();
        if (kind_q.size() != 0) begin
            protocol_error($sformatf("%0d requested frames never ran", kind_q.size()));
        end
        if (mean_q.size() != 0) begin
            protocol_error($sformatf("%0d expected means never appeared", mean_q.size()));
        end
        if (in_frame) begin
            protocol_error("a frame was still running at the end");
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            compare_value("cs", 1'b1, cs);
            compare_value("ready", 1'b0, ready);
            compare_value("sclk", 1'b1, sclk);
            compare_value("alarm", 1'b0, alarm);
            compare_value("sample.valid", 1'b0, sample.valid);
            compare_value("mean.valid", 1'b0, mean.valid);
            cs_prev = 1'b1;
            alarm_prev = 1'b0;
            exp_alarm = 1'b0;
            alarm_due = 1'b0;
            in_frame = 1'b0;
            block_sum = 0;
            block_count = 0;
        end else begin
            if (alarm_due) begin
                compare_value("alarm", exp_alarm, alarm);
                alarm_due = 1'b0;
            end else if (alarm !== alarm_prev) begin
                protocol_error("alarm changed without a new mean");
            end
            alarm_prev = alarm;
            if (mean.valid) begin
                check_mean();
            end
            if (cs_prev && !cs) begin
                start_frame();
            end
            if (!cs) begin
                low_cycles++;
            end
            if (cs && cs_prev) begin
                compare_value("sclk", 1'b1, sclk);  // Idles high between frames.
            end
            if (sample.valid) begin
                check_sample();
            end
            if (!cs_prev && cs) begin
                end_frame();
            end
            cs_prev = cs;
        end
    end

endmodule

`default_nettype wire

// File: adc_properties.sv
`default_nettype none

module adc_properties
    import adc_pkg::*;
(
    input logic         clk,
    input logic         reset,
    input logic         cs,
    input logic         ready,
    input sample_beat_t sample,
    input sample_beat_t mean
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    sample_single: assert property (@(posedge clk) disable iff (reset)
        sample.valid |=> !sample.valid)
        else begin
            fail_count++;
            $error("sample.valid stayed high for two cycles");
        end

    mean_single: assert property (@(posedge clk) disable iff (reset)
        mean.valid |=> !mean.valid)
        else begin
            fail_count++;
            $error("mean.valid stayed high for two cycles");
        end

    ready_idle: assert property (@(posedge clk) disable iff (reset)
        !(ready && !cs))
        else begin
            fail_count++;
            $error("ready is high while cs is low");
        end

    sample_in_frame: assert property (@(posedge clk) disable iff (reset)
        sample.valid |-> !cs)
        else begin
            fail_count++;
            $error("sample.valid while cs is high");
        end

endmodule

bind adc_top adc_properties prop0 (
    .clk    (clk),
    .reset  (reset),
    .cs     (cs),
    .ready  (ready),
    .sample (sample),
    .mean   (mean)
);

`default_nettype wire

// File: adc_top.sv
`default_nettype none

module adc_top
    import adc_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         read,
    input  logic         recalibrate,
    input  logic         sdo,
    output logic         cs,
    output logic         sclk,
    output logic         ready,
    output sample_beat_t sample,
    output sample_beat_t mean,
    output logic         alarm
);

    logic run;
    logic sclk_fall;
    logic sclk_rise;

    sclk_gen gen0 (
        .clk       (clk),
        .reset     (reset),
        .run       (run),
        .sclk      (sclk),
        .sclk_fall (sclk_fall),
        .sclk_rise (sclk_rise)
    );

    adc_serial_rx rx0 (
        .clk         (clk),
        .reset       (reset),
        .read        (read),
        .recalibrate (recalibrate),
        .sdo         (sdo),
        .sclk_fall   (sclk_fall),
        .sclk_rise   (sclk_rise),
        .run         (run),
        .cs          (cs),
        .ready       (ready),
        .sample      (sample)
    );

    sample_averager avg0 (
        .clk    (clk),
        .reset  (reset),
        .sample (sample),
        .mean   (mean)
    );

    level_monitor mon0 (
        .clk   (clk),
        .reset (reset),
        .mean  (mean),
        .alarm (alarm)
    );

endmodule

`default_nettype wire

// File: level_monitor.sv
`default_nettype none

`include "adc_cfg.svh"

module level_monitor
    import adc_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  sample_beat_t mean,
    output logic         alarm
);

    localparam sample_t alarm_high = sample_t'(`ADC_ALARM_HIGH);
    localparam sample_t alarm_low = sample_t'(`ADC_ALARM_LOW);

    logic above_high;
    logic below_low;

    assign above_high = (mean.data > alarm_high);
    assign below_low  = (mean.data < alarm_low);

    // Between the two thresholds the alarm keeps its last value.
    always_ff @(posedge clk) begin
        if (reset) begin
            alarm <= 1'b0;
        end else if (mean.valid) begin
            if (above_high) begin
                alarm <= 1'b1;
            end else if (below_low) begin
                alarm <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sample_averager.sv
`default_nettype none

`include "adc_cfg.svh"

module sample_averager
    import adc_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  sample_beat_t sample,
    output sample_beat_t mean
);

    localparam int avg_log2 = `ADC_AVG_LOG2;
    localparam int acc_w = $bits(acc_t);

    logic [avg_log2-1:0] count_q;     // Samples taken in the open block.
    logic                block_end;
    acc_t                sum_q;
    acc_t                sum_next;
    logic                mean_valid;
    sample_t             mean_data;

    // Counter wraps on its own at the block size.
    assign block_end = &count_q;

    // First sample of a block starts a fresh sum.
    always_comb begin
        sum_next = acc_t'(sample.data);
        if (count_q != '0) begin
            sum_next = sum_q + acc_t'(sample.data);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q    <= '0;
            mean_valid <= 1'b0;
        end else begin
            mean_valid <= 1'b0;
            if (sample.valid) begin
                count_q <= count_q + 1'b1;
                if (block_end) begin
                    mean_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample.valid) begin
            sum_q <= sum_next;
            if (block_end) begin
                mean_data <= sum_next[acc_w-1:avg_log2];  // Truncating divide.
            end
        end
    end

    assign mean = '{valid: mean_valid, data: mean_data};

endmodule

`default_nettype wire

// File: adc_serial_rx.sv
`default_nettype none

`include "adc_cfg.svh"

module adc_serial_rx
    import adc_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         read,
    input  logic         recalibrate,
    input  logic         sdo,
    input  logic         sclk_fall,
    input  logic         sclk_rise,
    output logic         run,
    output logic         cs,
    output logic         ready,
    output sample_beat_t sample
);

    localparam int cnt_w = $clog2(`ADC_CAL_BITS + 1);
    localparam logic [cnt_w-1:0] frame_bits = cnt_w'(`ADC_FRAME_BITS);
    localparam logic [cnt_w-1:0] lead_bits = cnt_w'(`ADC_LEAD_BITS);
    localparam logic [cnt_w-1:0] cal_bits = cnt_w'(`ADC_CAL_BITS);
    localparam logic [cnt_w-1:0] last_bit = cnt_w'(`ADC_FRAME_BITS - 1);

    rx_state_t        state;
    logic [cnt_w-1:0] bit_cnt;     // sclk rises seen in the current frame.
    logic             read_pend;
    logic             cal_pend;
    logic             sample_valid;
    sample_t          shift_q;

    assign run   = ~cs;
    assign ready = (state == idle) && !read_pend && !cal_pend;

    assign sample = '{valid: sample_valid, data: shift_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= init;
            cs           <= 1'b1;
            bit_cnt      <= '0;
            read_pend    <= 1'b0;
            cal_pend     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;

            // Requests only count while ready is shown.
            if (ready && read) begin
                read_pend <= 1'b1;
            end
            if (ready && recalibrate) begin
                cal_pend <= 1'b1;
            end

            if (sclk_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            case (state)
                init: begin
                    if (sclk_fall) begin
                        state   <= calibrate;  // Power-up calibration.
                        cs      <= 1'b0;
                        bit_cnt <= '0;
                    end
                end

                calibrate: begin
                    if (sclk_fall && bit_cnt == cal_bits) begin
                        state <= idle;
                        cs    <= 1'b1;
                    end
                end

                idle: begin
                    if (sclk_fall && (cal_pend || read_pend)) begin
                        state     <= cal_pend ? calibrate : receive;  // Recalibrate wins.
                        cs        <= 1'b0;
                        bit_cnt   <= '0;
                        read_pend <= 1'b0;
                        cal_pend  <= 1'b0;
                    end
                end

                receive: begin
                    if (sclk_rise && bit_cnt == last_bit) begin
                        sample_valid <= 1'b1;  // Last data bit lands this edge.
                    end
                    if (sclk_fall && bit_cnt == frame_bits) begin
                        state <= idle;
                        cs    <= 1'b1;
                    end
                end

                default: begin
                    state <= init;
                end
            endcase
        end
    end

    // Leading zeros are skipped, data arrives MSB first.
    always_ff @(posedge clk) begin
        if (state == receive && sclk_rise && bit_cnt >= lead_bits) begin
            shift_q <= {shift_q[`ADC_SAMPLE_BITS-2:0], sdo};
        end
    end

endmodule

`default_nettype wire

// File: sclk_gen.sv
`default_nettype none

`include "adc_cfg.svh"

module sclk_gen (
    input  logic clk,
    input  logic reset,
    input  logic run,
    output logic sclk,
    output logic sclk_fall,
    output logic sclk_rise
);

    localparam int half = `ADC_SCLK_HALF;
    localparam int cnt_w = (half > 1) ? $clog2(half) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half - 1);

    logic [cnt_w-1:0] half_cnt;
    logic             phase;      // Free-running sclk level, keeps going while idle.
    logic             half_done;

    assign half_done = (half_cnt == cnt_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            half_cnt  <= '0;
            phase     <= 1'b1;
            sclk      <= 1'b1;
            sclk_fall <= 1'b0;
            sclk_rise <= 1'b0;
        end else begin
            sclk_fall <= 1'b0;
            sclk_rise <= 1'b0;
            if (half_done) begin
                half_cnt  <= '0;
                phase     <= ~phase;
                // Pin only follows the phase while a frame runs.
                sclk      <= ~(phase & run);
                sclk_fall <= phase;           // Cadence kept even when idle.
                sclk_rise <= ~phase & run;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: adc_pkg.sv
`default_nettype none

`include "adc_cfg.svh"

package adc_pkg;

    // One ADC code.
    typedef logic [`ADC_SAMPLE_BITS-1:0] sample_t;

    // Holds the sum of one averaging block without overflow.
    typedef logic [`ADC_SAMPLE_BITS+`ADC_AVG_LOG2-1:0] acc_t;

    typedef enum logic [1:0] {
        init,
        calibrate,
        idle,
        receive
    } rx_state_t;

    // One item between stages, valid for a single clk cycle.
    typedef struct packed {
        logic    valid;
        sample_t data;
    } sample_beat_t;

endpackage

`default_nettype wire

// File: adc_cfg.svh
`ifndef ADC_CFG_SVH
`define ADC_CFG_SVH

// Width of one ADC code.
`define ADC_SAMPLE_BITS 12

`define ADC_SCLK_HALF 2       // clk cycles per sclk half period.

// Frame lengths, counted in sclk periods with cs low.
`define ADC_FRAME_BITS 16
`define ADC_LEAD_BITS 4       // Zeros ahead of the data bits.
`define ADC_CAL_BITS 32

// Block of 2**ADC_AVG_LOG2 samples per mean.
`define ADC_AVG_LOG2 2

`define ADC_ALARM_HIGH 3000   // Mean above this sets the alarm.
`define ADC_ALARM_LOW 1000    // Mean below this clears it.

`endif
